// ==== src/sensor_emu_settings.svh ====
`ifndef SENSOR_EMU_SETTINGS_SVH
`define SENSOR_EMU_SETTINGS_SVH

// horizontal segments, pixel clocks
`define H_SYNC        4
`define H_BACK        4
`define H_ACTIVE      16
`define H_FRONT       4
`define H_TOTAL       (`H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT)   // 28 clocks per line

// vertical segments, lines
`define V_SYNC        2
`define V_BACK        1
`define V_ACTIVE      8
`define V_FRONT       1
`define V_TOTAL       (`V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT)   // 12 lines per frame

`define WARMUP_CYCLES 16                  // idle clocks before first line
`define PIX_W         10                  // raw pixel width
`define FRAME_CNT_W   16
`define BAR_WIDTH     (`H_ACTIVE / 4)     // four colour bars
`define COL_W         $clog2(`H_ACTIVE)
`define ROW_W         $clog2(`V_ACTIVE)

// register map
`define ADDR_CTRL     4'h0
`define ADDR_SOLID    4'h4
`define ADDR_STATUS   4'h8

`endif

// ==== src/sensor_emu_pkg.sv ====
package sensor_emu_pkg;

    // test pattern select, code 3 falls back to bars
    typedef enum logic [1:0] {
        PAT_BARS  = 2'd0,
        PAT_SOLID = 2'd1,
        PAT_RAMP  = 2'd2
    } pattern_mode_e;

    // raster sequencer states
    typedef enum logic [1:0] {
        RST_IDLE   = 2'd0,   // waiting for enable
        RST_WARMUP = 2'd1,   // start-up delay
        RST_RUN    = 2'd2    // counting pixels and lines
    } raster_state_e;

    // axi4-lite response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// ==== src/raster_if.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

// raster position and strobes, timing generator to pattern generator
interface raster_if;

    logic [`COL_W-1:0] col;     // active column, only meaningful while active
    logic [`ROW_W-1:0] row;     // active row
    logic              fv;      // frame valid
    logic              lv;      // line valid
    logic              active;  // pixel enable condition

    modport src (
        output col, row, fv, lv, active
    );

    modport dst (
        input col, row, fv, lv, active
    );

endinterface

// ==== src/cfg_regs.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

module cfg_regs (
    input  logic                          clk,
    input  logic                          reset_n,
    // write address / data / response
    input  logic [3:0]                    awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,      // not decoded, whole word writes
    input  logic                          wvalid,
    output logic                          wready,
    output sensor_emu_pkg::axi_resp_e     bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // read address / data
    input  logic [3:0]                    araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output sensor_emu_pkg::axi_resp_e     rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // datapath side
    input  logic [`FRAME_CNT_W-1:0]       frame_count,
    output logic                          enable,
    output sensor_emu_pkg::pattern_mode_e mode,
    output logic [`PIX_W-1:0]             solid_level
);

    logic wr_fire;  // aw and w handshake this cycle
    logic rd_fire;  // ar handshake this cycle

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;

    // write channel, one transaction outstanding
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            enable      <= 1'b0;
            mode        <= sensor_emu_pkg::PAT_BARS;
            solid_level <= '0;
        end else begin
            awready <= 1'b0;    // single cycle pulse
            wready  <= 1'b0;
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end

            if (wr_fire) begin
                bvalid <= 1'b1;
                case (awaddr)
                    `ADDR_CTRL: begin
                        enable <= wdata[0];
                        mode   <= sensor_emu_pkg::pattern_mode_e'(wdata[2:1]);
                    end
                    `ADDR_SOLID: solid_level <= wdata[`PIX_W-1:0];
                    default: ;  // status and holes left untouched
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0; // response taken
            end
        end
    end

    // write response code, follows the accepted address
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (awaddr == `ADDR_CTRL || awaddr == `ADDR_SOLID)
                bresp <= sensor_emu_pkg::RESP_OKAY;
            else
                bresp <= sensor_emu_pkg::RESP_SLVERR; // status is read only
        end
    end

    // read channel handshake
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;  // pulse, none pending
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    // read data mux, registered on the ar handshake
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rresp <= sensor_emu_pkg::RESP_OKAY;
            case (araddr)
                `ADDR_CTRL:   rdata <= {29'd0, mode, enable};
                `ADDR_SOLID:  rdata <= 32'(solid_level);
                `ADDR_STATUS: rdata <= 32'(frame_count);   // live count
                default: begin
                    rdata <= 32'd0;
                    rresp <= sensor_emu_pkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

// ==== src/raster_timing.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

module raster_timing (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable,
    output logic [`FRAME_CNT_W-1:0] frame_count,
    raster_if.src                   raster
);

    localparam int X_W    = $clog2(`H_TOTAL);
    localparam int Y_W    = $clog2(`V_TOTAL);
    localparam int WARM_W = $clog2(`WARMUP_CYCLES);
    localparam int COL_W  = `COL_W;
    localparam int ROW_W  = `ROW_W;
    localparam int H_ACT0 = `H_SYNC + `H_BACK;  // first active column in x
    localparam int V_ACT0 = `V_SYNC + `V_BACK;  // first active row in y

    sensor_emu_pkg::raster_state_e state;
    logic [WARM_W-1:0] warm_cnt;
    logic [X_W-1:0]    x;
    logic [Y_W-1:0]    y;
    logic              line_end;
    logic              frame_end;
    logic              running;
    logic              act_row;   // y inside the active lines

    assign running   = (state == sensor_emu_pkg::RST_RUN);
    assign line_end  = (x == X_W'(`H_TOTAL - 1));
    assign frame_end = line_end && (y == Y_W'(`V_TOTAL - 1));
    assign act_row   = (y >= V_ACT0) && (y < V_ACT0 + `V_ACTIVE);

    // sequencer and counters
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state       <= sensor_emu_pkg::RST_IDLE;
            warm_cnt    <= '0;
            x           <= '0;
            y           <= '0;
            frame_count <= '0;
        end else begin
            case (state)
                sensor_emu_pkg::RST_IDLE: begin
                    warm_cnt <= '0;
                    if (enable)
                        state <= sensor_emu_pkg::RST_WARMUP;
                end
                sensor_emu_pkg::RST_WARMUP: begin
                    warm_cnt <= warm_cnt + 1'b1;
                    if (warm_cnt == WARM_W'(`WARMUP_CYCLES - 1)) begin
                        state <= sensor_emu_pkg::RST_RUN;
                        x     <= '0;    // start at top left
                        y     <= '0;
                    end
                end
                sensor_emu_pkg::RST_RUN: begin
                    if (!line_end) begin
                        x <= x + 1'b1;
                    end else begin
                        x <= '0;
                        y <= frame_end ? '0 : y + 1'b1;
                    end
                    if (frame_end) begin
                        frame_count <= frame_count + 1'b1;
                        if (!enable)
                            state <= sensor_emu_pkg::RST_IDLE;  // stop only at frame boundary
                    end
                end
                default: state <= sensor_emu_pkg::RST_IDLE;
            endcase
        end
    end

    // strobes, one cycle behind the counters
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            raster.fv     <= 1'b0;
            raster.lv     <= 1'b0;
            raster.active <= 1'b0;
        end else begin
            raster.fv     <= running && (y >= `V_SYNC);
            raster.lv     <= running && act_row && (x >= `H_SYNC);
            raster.active <= running && act_row && (x >= H_ACT0) && (x < H_ACT0 + `H_ACTIVE);
        end
    end

    // active coordinates, wrap outside the window and are ignored there
    always_ff @(posedge clk) begin
        raster.col <= COL_W'(x - X_W'(H_ACT0));
        raster.row <= ROW_W'(y - Y_W'(V_ACT0));
    end

endmodule

// ==== src/bayer_pattern.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

module bayer_pattern (
    input  logic                          clk,
    input  logic                          reset_n,
    input  sensor_emu_pkg::pattern_mode_e mode,
    input  logic [`PIX_W-1:0]             solid_level,
    raster_if.dst                         raster,
    output logic                          fv,
    output logic                          lv,
    output logic                          pix_en,
    output logic [`PIX_W-1:0]             pix_data
);

    localparam logic [`PIX_W-1:0] FULL = '1;  // 0x3ff

    logic [1:0]        bar;         // colour bar index
    logic              site_r;
    logic              site_gr;
    logic              site_gb;
    logic              site_b;
    logic              bar_on;      // site lit in the current bar
    logic [`PIX_W-1:0] pix_val;

    assign bar = 2'(raster.col / `BAR_WIDTH);

    // rggb phase from row and column parity
    always_comb begin
        site_r  =  raster.row[0] &&  raster.col[0];
        site_gr =  raster.row[0] && !raster.col[0];
        site_gb = !raster.row[0] &&  raster.col[0];
        site_b  = !raster.row[0] && !raster.col[0];
    end

    always_comb begin
        case (bar)
            2'd0:    bar_on = 1'b1;                 // white
            2'd1:    bar_on = site_r || site_b;     // magenta
            2'd2:    bar_on = site_gr || site_gb;   // green
            default: bar_on = site_r || site_gr;    // odd rows only
        endcase
    end

    always_comb begin
        case (mode)
            sensor_emu_pkg::PAT_SOLID: pix_val = solid_level;
            sensor_emu_pkg::PAT_RAMP:  pix_val = `PIX_W'(raster.col) << 6;   // col * 64
            default:                   pix_val = bar_on ? FULL : '0;        // bars, also code 3
        endcase
    end

    // output stage, strobes re-registered to line up with data
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            fv       <= 1'b0;
            lv       <= 1'b0;
            pix_en   <= 1'b0;
            pix_data <= '0;
        end else begin
            fv       <= raster.fv;
            lv       <= raster.lv;
            pix_en   <= raster.active;
            pix_data <= raster.active ? pix_val : '0;  // blank outside active
        end
    end

endmodule

// ==== src/sensor_emu_top.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

module sensor_emu_top (
    input  logic              clk,
    input  logic              reset_n,
    // axi4-lite slave
    input  logic [3:0]        awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [3:0]        araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    // raw video out
    output logic              fv,
    output logic              lv,
    output logic              pix_en,
    output logic [`PIX_W-1:0] pix_data
);

    logic                          enable;
    sensor_emu_pkg::pattern_mode_e mode;
    logic [`PIX_W-1:0]             solid_level;
    logic [`FRAME_CNT_W-1:0]       frame_count;

    raster_if raster_bus ();    // timing to pattern

    cfg_regs cfg_regs_i (
        .clk, .reset_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .frame_count, .enable, .mode, .solid_level
    );

    raster_timing raster_timing_i (
        .clk, .reset_n, .enable, .frame_count,
        .raster (raster_bus.src)
    );

    bayer_pattern bayer_pattern_i (
        .clk, .reset_n, .mode, .solid_level,
        .raster (raster_bus.dst),
        .fv, .lv, .pix_en, .pix_data
    );

endmodule

// ==== tests/sensor_emu_sva.sv ====
`timescale 1ns/100ps

module sensor_emu_sva (
    input logic clk,
    input logic reset_n,
    input logic fv,
    input logic lv,
    input logic pix_en,
    input logic awready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    // strobes nest, pixel inside line inside frame
    pix_in_line: assert property (@(posedge clk) disable iff (!reset_n) pix_en |-> lv)
        else $error("pix_en high while lv is low");
    line_in_frame: assert property (@(posedge clk) disable iff (!reset_n) lv |-> fv)
        else $error("lv high while fv is low");

    // responses wait for the master
    bvalid_held: assert property (@(posedge clk) disable iff (!reset_n)
                                  bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    rvalid_held: assert property (@(posedge clk) disable iff (!reset_n)
                                  rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    awready_pulse: assert property (@(posedge clk) disable iff (!reset_n) awready |=> !awready)
        else $error("awready high for more than one cycle");

endmodule

bind sensor_emu_top sensor_emu_sva sensor_emu_sva_i (
    .clk, .reset_n, .fv, .lv, .pix_en,
    .awready, .bvalid, .bready, .rvalid, .rready
);

// ==== tests/sensor_emu_tb.sv ====
`timescale 1ns/100ps
`include "sensor_emu_settings.svh"

module sensor_emu_tb;

    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;   // 336 clocks per frame
    localparam int NUM_ROWS   = 22;
    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_CAPTURE = 2;     // grab one frame and check every pixel
    localparam int OP_STATUS  = 3;     // status read against counted frame ends
    localparam int OP_STOP    = 4;     // video must go quiet
    localparam sensor_emu_pkg::axi_resp_e     OK    = sensor_emu_pkg::RESP_OKAY;
    localparam sensor_emu_pkg::axi_resp_e     ERR   = sensor_emu_pkg::RESP_SLVERR;
    localparam sensor_emu_pkg::pattern_mode_e BARS  = sensor_emu_pkg::PAT_BARS;
    localparam sensor_emu_pkg::pattern_mode_e SOLID = sensor_emu_pkg::PAT_SOLID;
    localparam sensor_emu_pkg::pattern_mode_e RAMP  = sensor_emu_pkg::PAT_RAMP;

    typedef struct packed {
        int                            op;
        logic [3:0]                    addr;
        logic [31:0]                   data;   // write data, read data or pixel level
        sensor_emu_pkg::axi_resp_e     resp;
        sensor_emu_pkg::pattern_mode_e mode;   // expected pattern on capture rows
    } row_t;

    logic              clk = 1'b0;
    logic              reset_n;
    logic [3:0]        awaddr;
    logic              awvalid;
    logic              awready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [3:0]        araddr;
    logic              arvalid;
    logic              arready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              fv;
    logic              lv;
    logic              pix_en;
    logic [`PIX_W-1:0] pix_data;

    logic [31:0] lfsr = 32'h72e68714;
    int          frame_ends = 0;   // fv falling edges seen
    logic        fv_seen = 1'b0;
    row_t        tbl [NUM_ROWS];

    sensor_emu_top sensor_emu_top_i (.*);

    always #10 clk = ~clk;   // 20 ns period

    // frame end counter sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_n) begin
            fv_seen    <= 1'b0;
            frame_ends <= 0;
        end else begin
            if (fv_seen && !fv)
                frame_ends <= frame_ends + 1;
            fv_seen <= fv;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;   // outputs settled and inputs change here
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);   // galois with taps 32 30 26 25
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_resp(input string name, input sensor_emu_pkg::axi_resp_e exp,
                              input sensor_emu_pkg::axi_resp_e act);
        if (exp !== act)
            abort_run($sformatf("mismatch at %0t: %s expected %0d got %0d",
                                $time, name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act)
            abort_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_pixel(input string name, input logic [`PIX_W-1:0] exp,
                               input logic [`PIX_W-1:0] act);
        if (exp !== act)
            abort_run($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp !== act)
            abort_run($sformatf("mismatch at %0t: %s expected %0d got %0d",
                                $time, name, exp, act));
    endtask

    function automatic row_t make_row(input int op, input logic [3:0] addr,
                                      input logic [31:0] data,
                                      input sensor_emu_pkg::axi_resp_e resp,
                                      input sensor_emu_pkg::pattern_mode_e mode);
        return '{op, addr, data, resp, mode};
    endfunction

    // reference pixel straight from the bayer rules
    function automatic logic [`PIX_W-1:0] expect_pixel(input sensor_emu_pkg::pattern_mode_e m,
                                                       input logic [`PIX_W-1:0] lvl,
                                                       input int c, input int r);
        logic [3:0] lit;   // lit sites of the bar as {r, gr, gb, b}
        int         site;  // bit index into lit
        case (c / `BAR_WIDTH)
            0:       lit = 4'b1111;   // white
            1:       lit = 4'b1001;   // r and b
            2:       lit = 4'b0110;   // greens
            default: lit = 4'b1100;   // r and gr
        endcase
        if (r % 2 == 1)
            site = (c % 2 == 1) ? 3 : 2;
        else
            site = (c % 2 == 1) ? 1 : 0;
        case (m)
            sensor_emu_pkg::PAT_SOLID: return lvl;
            sensor_emu_pkg::PAT_RAMP:  return `PIX_W'(c * 64);   // wraps past 10 bits
            default:                   return lit[site] ? {`PIX_W{1'b1}} : '0;
        endcase
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output sensor_emu_pkg::axi_resp_e resp);
        int          guard;
        logic [31:0] stall;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        guard   = 0;
        while (!awready) begin
            next_cycle();
            guard++;
            if (guard > 20)
                abort_run("write address was never accepted");
        end
        check_count("wready with awready", 1, int'(wready));   // both pulse together
        next_cycle();   // handshake edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        guard   = 0;
        while (!bvalid) begin
            next_cycle();
            guard++;
            if (guard > 20)
                abort_run("no write response arrived");
        end
        draw_bits(3, stall);
        repeat (int'(stall)) next_cycle();   // bready held off while bvalid must stay
        resp   = sensor_emu_pkg::axi_resp_e'(bresp);
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output sensor_emu_pkg::axi_resp_e resp);
        int          guard;
        logic [31:0] stall;
        araddr  = addr;
        arvalid = 1'b1;
        guard   = 0;
        while (!arready) begin
            next_cycle();
            guard++;
            if (guard > 20)
                abort_run("read address was never accepted");
        end
        next_cycle();
        arvalid = 1'b0;
        guard   = 0;
        while (!rvalid) begin
            next_cycle();
            guard++;
            if (guard > 20)
                abort_run("no read data arrived");
        end
        draw_bits(3, stall);
        repeat (int'(stall)) next_cycle();   // rready stall
        data   = rdata;
        resp   = sensor_emu_pkg::axi_resp_e'(rresp);
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic wait_fv(input logic level);
        int guard;
        guard = 0;
        while (fv !== level) begin
            next_cycle();
            guard++;
            if (guard > 3 * FRAME_CLKS)
                abort_run($sformatf("fv never went to %0d", level));
        end
    endtask

    // waits for a fresh frame and walks it pixel by pixel
    task automatic capture_frame(input sensor_emu_pkg::pattern_mode_e m,
                                 input logic [`PIX_W-1:0] lvl);
        int   col;
        int   row;
        int   guard;
        int   lv_cycles;   // lv high clocks inside the frame
        logic en_prev;
        wait_fv(1'b0);
        wait_fv(1'b1);
        col       = 0;
        row       = 0;
        guard     = 0;
        lv_cycles = 0;
        en_prev   = 1'b0;
        while (fv) begin
            if (lv)
                lv_cycles++;
            if (pix_en) begin
                check_pixel($sformatf("pix_data row %0d col %0d", row, col),
                            expect_pixel(m, lvl, col, row), pix_data);
                col++;
            end else if (en_prev) begin   // line just ended
                check_count("pixels per line", `H_ACTIVE, col);
                col = 0;
                row++;
            end
            en_prev = pix_en;
            next_cycle();
            guard++;
            if (guard > FRAME_CLKS)
                abort_run("fv stayed high longer than a frame");
        end
        check_count("lines per frame", `V_ACTIVE, row);
        check_count("lv cycles per frame", `V_ACTIVE * (`H_TOTAL - `H_SYNC), lv_cycles);
    endtask

    // fv must stay low for two frame times once the last frame is out
    task automatic wait_stopped();
        int quiet;
        int guard;
        quiet = 0;
        guard = 0;
        while (quiet < 2 * FRAME_CLKS) begin
            quiet = fv ? 0 : quiet + 1;
            next_cycle();
            guard++;
            if (guard > 5 * FRAME_CLKS)
                abort_run("video kept running after enable was cleared");
        end
    endtask

    initial begin
        row_t                      r;
        logic [31:0]               lvl_a;
        logic [31:0]               lvl_b;
        logic [31:0]               rd;
        sensor_emu_pkg::axi_resp_e resp;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(posedge clk);
        #2 reset_n = 1'b1;

        // quiet outputs before any register write
        for (int i = 0; i < 400; i++) begin
            check_count("fv lv pix_en bvalid rvalid", 0, int'({fv, lv, pix_en, bvalid, rvalid}));
            next_cycle();
        end

        draw_bits(`PIX_W, lvl_a);   // random solid levels
        draw_bits(`PIX_W, lvl_b);
        tbl[0]  = make_row(OP_WRITE, `ADDR_CTRL, 32'h2, OK, BARS);     // solid but still off
        tbl[1]  = make_row(OP_READ, `ADDR_CTRL, 32'h2, OK, BARS);
        tbl[2]  = make_row(OP_WRITE, `ADDR_SOLID, lvl_a, OK, BARS);
        tbl[3]  = make_row(OP_READ, `ADDR_SOLID, lvl_a, OK, BARS);
        tbl[4]  = make_row(OP_WRITE, `ADDR_STATUS, 32'h1234, ERR, BARS);   // read only
        tbl[5]  = make_row(OP_STATUS, 4'h0, 32'h0, OK, BARS);
        tbl[6]  = make_row(OP_WRITE, 4'hc, 32'h55, ERR, BARS);         // hole
        tbl[7]  = make_row(OP_READ, 4'hc, 32'h0, ERR, BARS);
        tbl[8]  = make_row(OP_WRITE, `ADDR_CTRL, 32'h1, OK, BARS);     // enable with bars
        tbl[9]  = make_row(OP_CAPTURE, 4'h0, 32'h0, OK, BARS);
        tbl[10] = make_row(OP_CAPTURE, 4'h0, 32'h0, OK, BARS);
        tbl[11] = make_row(OP_WRITE, `ADDR_CTRL, 32'h3, OK, BARS);
        tbl[12] = make_row(OP_CAPTURE, 4'h0, lvl_a, OK, SOLID);
        tbl[13] = make_row(OP_WRITE, `ADDR_SOLID, lvl_b, OK, BARS);    // level change
        tbl[14] = make_row(OP_CAPTURE, 4'h0, lvl_b, OK, SOLID);
        tbl[15] = make_row(OP_WRITE, `ADDR_CTRL, 32'h5, OK, BARS);
        tbl[16] = make_row(OP_CAPTURE, 4'h0, 32'h0, OK, RAMP);
        tbl[17] = make_row(OP_WRITE, `ADDR_CTRL, 32'h7, OK, BARS);     // code 3
        tbl[18] = make_row(OP_CAPTURE, 4'h0, 32'h0, OK, BARS);
        tbl[19] = make_row(OP_WRITE, `ADDR_CTRL, 32'h0, OK, BARS);     // disable
        tbl[20] = make_row(OP_STOP, 4'h0, 32'h0, OK, BARS);
        tbl[21] = make_row(OP_STATUS, 4'h0, 32'h0, OK, BARS);

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = tbl[i];
            case (r.op)
                OP_WRITE: begin
                    axi_write(r.addr, r.data, resp);
                    check_resp("bresp", r.resp, resp);
                end
                OP_READ: begin
                    axi_read(r.addr, rd, resp);
                    check_resp("rresp", r.resp, resp);
                    check_data("rdata", r.data, rd);
                end
                OP_CAPTURE: capture_frame(r.mode, r.data[`PIX_W-1:0]);
                OP_STATUS: begin
                    axi_read(`ADDR_STATUS, rd, resp);
                    check_resp("rresp", OK, resp);
                    check_data("rdata frame count", 32'(frame_ends), rd);
                end
                OP_STOP: wait_stopped();
                default: abort_run("unknown operation in the stimulus table");
            endcase
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/sensor_emu_pkg.sv
src/raster_if.sv
src/cfg_regs.sv
src/raster_timing.sv
src/bayer_pattern.sv
src/sensor_emu_top.sv
tests/sensor_emu_sva.sv
tests/sensor_emu_tb.sv

// ==== Makefile ====
TOP := sensor_emu_tb

.PHONY: sim clean

# build and run; the status comes from the search for the pass line
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
